// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_proc
FILELIST  := proc.f
FLAGS     := --binary --timing --assert -j 0
MDIR      := obj_dir
BIN       := $(MDIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(MDIR)

// ==== dv/tb_proc.sv ====
// ############################################################################
// Testbench for proc. Random programs use forward branches only and end
// in HALT; an in-order ISA model predicts every register write and store.
// Data memory is 256 words, indexed by the low byte of the address.
// The second, short run holds one illegal opcode and expects a sticky err.
// ############################################################################
`timescale 1ns/10ps
`default_nettype none

module tb_proc import procPkg::*; ();

   localparam int clkPeriod     = 10;
   localparam int resetCycles   = 16;
   localparam int mainLen       = 200;
   localparam int shortLen      = 40;
   localparam int cyclesPerInst = 8;
   localparam int watchdogNs    = (mainLen + shortLen) * cyclesPerInst * clkPeriod
                                  + 2 * resetCycles * clkPeriod + 20 * clkPeriod;

   logic   clk          = 1'b0;
   logic   reset        = 1'b1;
   dataT   instData     = '0;
   dataT   dmemReadData = '0;
   dataT   instAddr, dmemAddr, dmemWriteData, wbData;
   logic   dmemWrite, dmemRead, wbValid, halt, err;
   regSelT wbReg;

   integer     seed = 32'h2828d1cd;
   dataT       imem [256];
   dataT       dmem [256];
   dataT       modelMem [256];
   int         progLen = 0;
   logic       fillDmem = 1'b0;
   logic       storePending = 1'b0;
   logic [7:0] storeIdx;
   dataT       storeValue;
   regSelT     expReg [$];
   dataT       expWbData [$];
   dataT       expAddr [$];
   dataT       expStData [$];
   logic       errSeen, haltSeen;
   int         writesSeen, storesSeen;

   proc dut (
      .clk           (clk),
      .reset         (reset),
      .instAddr      (instAddr),
      .instData      (instData),
      .dmemAddr      (dmemAddr),
      .dmemWriteData (dmemWriteData),
      .dmemWrite     (dmemWrite),
      .dmemRead      (dmemRead),
      .dmemReadData  (dmemReadData),
      .wbValid       (wbValid),
      .wbReg         (wbReg),
      .wbData        (wbData),
      .halt          (halt),
      .err           (err)
   );

   always #(clkPeriod / 2) clk = ~clk;

   function automatic int pick(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic int minInt(int a, int b);
      return (a < b) ? a : b;
   endfunction

   // odd multiplier, so every word differs
   function automatic dataT dmemInit(int idx);
      return 16'(idx * 40501 + 23609);
   endfunction

   function automatic dataT sext5(logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   function automatic dataT sext11(logic [10:0] v);
      return {{5{v[10]}}, v};
   endfunction

   function automatic dataT aluRule(logic [1:0] func, dataT a, dataT b);
      case (func)
         2'd0:    return a + b;
         2'd1:    return a - b;
         2'd2:    return a ^ b;
         default: return a & ~b;   // andn
      endcase
   endfunction

   function automatic dataT fetchWord(dataT addr);
      int idx;
      idx = 32'(addr[15:1]);
      if (idx < progLen)
         return imem[8'(idx)];
      return {opHalt, 11'b0};   // past the end of the program
   endfunction

   // both memories read combinationally, driven mid-cycle
   always @(negedge clk) begin
      instData     <= fetchWord(instAddr);
      dmemReadData <= dmem[dmemAddr[7:0]];
   end

   always @(posedge clk) begin
      if (fillDmem) begin
         for (int i = 0; i < 256; i++)
            dmem[8'(i)] <= dmemInit(i);
      end else if (storePending) begin
         dmem[storeIdx] <= storeValue;   // store lands on the rising edge
      end
   end

   task automatic failRun(string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic verifyFlag(string name, logic got, logic exp);
      if (got !== exp)
         failRun($sformatf("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp));
   endtask

   task automatic checkWriteback(regSelT dest, dataT data);
      regSelT expDest;
      dataT   expData;
      if (expReg.size() == 0) begin
         failRun($sformatf("unexpected register write r%0d = %h at %0t ns", dest, data, $time));
      end else begin
         expDest = expReg.pop_front();
         expData = expWbData.pop_front();
         if (dest !== expDest || data !== expData)
            failRun($sformatf("Mismatch at %0t ns: writeback r%0d = %h, expected r%0d = %h",
                              $time, dest, data, expDest, expData));
         writesSeen++;
      end
   endtask

   task automatic checkStore(dataT addr, dataT data);
      dataT wantAddr;
      dataT wantData;
      if (expAddr.size() == 0) begin
         failRun($sformatf("unexpected store of %h to %h at %0t ns", data, addr, $time));
      end else begin
         wantAddr = expAddr.pop_front();
         wantData = expStData.pop_front();
         if (addr !== wantAddr || data !== wantData)
            failRun($sformatf("Mismatch at %0t ns: store %h to %h, expected %h to %h",
                              $time, data, addr, wantData, wantAddr));
         storesSeen++;
      end
   endtask

   // random body, then HALT; branch targets never pass limit
   task automatic buildProgram(input int len, input int illegalAt);
      instT w;
      int   limit;
      int   kind;
      for (int i = 0; i < len; i++) begin
         w     = '0;
         limit = (i < illegalAt) ? illegalAt : len;   // illegal word is always reached
         kind  = pick(16);
         if (i == illegalAt) begin
            w = {5'b11111, 11'(pick(2048))};
         end else if (kind < 4) begin
            w.rFmt.opcode = opAlu;
            w.rFmt.rs     = 3'(pick(8));
            w.rFmt.rt     = 3'(pick(8));
            w.rFmt.rd     = 3'(pick(8));
            w.rFmt.func   = 2'(kind);
         end else if (kind < 14) begin
            case (kind)
               4, 5:    w.iFmt.opcode = opAddi;
               6:       w.iFmt.opcode = opXori;
               7:       w.iFmt.opcode = opAndni;
               8, 9:    w.iFmt.opcode = opLd;
               10, 11:  w.iFmt.opcode = opSt;
               12:      w.iFmt.opcode = opBeqz;
               default: w.iFmt.opcode = opBnez;
            endcase
            w.iFmt.rd  = 3'(pick(8));
            w.iFmt.rs  = 3'(pick(8));
            w.iFmt.imm = 5'(pick(32));
            if (kind >= 12)
               w.iFmt.imm = 5'(2 * pick(minInt(7, limit - i - 1) + 1));
         end else if (kind == 14) begin
            w.jFmt.opcode = opJ;
            w.jFmt.disp   = 11'(2 * pick(minInt(30, limit - i - 1) + 1));
         end else begin
            w.jFmt.opcode = opNop;
         end
         imem[8'(i)] = w;
      end
      imem[8'(len)] = {opHalt, 11'b0};
      progLen       = len + 1;
   endtask

   // in-order ISA model, fills the expected queues
   task automatic runModel(output logic sawIllegal);
      dataT   regs [8];
      dataT   pc, addr, res;
      instT   w;
      regSelT dest;
      logic   done, writes;
      int     steps;
      sawIllegal = 1'b0;
      done       = 1'b0;
      steps      = 0;
      pc         = '0;
      for (int i = 0; i < 8; i++)
         regs[3'(i)] = '0;
      for (int i = 0; i < 256; i++)
         modelMem[8'(i)] = dmemInit(i);
      expReg.delete();
      expWbData.delete();
      expAddr.delete();
      expStData.delete();
      while (!done) begin
         w      = imem[pc[8:1]];
         pc     = pc + 16'd2;
         steps  = steps + 1;
         writes = 1'b0;
         dest   = w.iFmt.rd;
         addr   = regs[w.iFmt.rs] + sext5(w.iFmt.imm);
         res    = '0;
         case (w.rFmt.opcode)
            opAlu: begin
               dest   = w.rFmt.rd;
               res    = aluRule(w.rFmt.func, regs[w.rFmt.rs], regs[w.rFmt.rt]);
               writes = 1'b1;
            end
            opAddi: begin
               res    = aluRule(2'd0, regs[w.iFmt.rs], sext5(w.iFmt.imm));
               writes = 1'b1;
            end
            opXori: begin
               res    = aluRule(2'd2, regs[w.iFmt.rs], sext5(w.iFmt.imm));
               writes = 1'b1;
            end
            opAndni: begin
               res    = aluRule(2'd3, regs[w.iFmt.rs], sext5(w.iFmt.imm));
               writes = 1'b1;
            end
            opLd: begin
               res    = modelMem[addr[7:0]];
               writes = 1'b1;
            end
            opSt: begin
               modelMem[addr[7:0]] = regs[w.iFmt.rd];
               expAddr.push_back(addr);
               expStData.push_back(regs[w.iFmt.rd]);
            end
            opBeqz: if (regs[w.iFmt.rs] == '0) pc = pc + sext5(w.iFmt.imm);
            opBnez: if (regs[w.iFmt.rs] != '0) pc = pc + sext5(w.iFmt.imm);
            opJ:    pc = pc + sext11(w.jFmt.disp);
            opNop:  ;
            opHalt: done = 1'b1;
            default: sawIllegal = 1'b1;   // behaves as NOP
         endcase
         if (writes) begin
            regs[dest] = res;
            expReg.push_back(dest);
            expWbData.push_back(res);
         end
         if (steps > 4 * progLen)
            failRun("model did not reach HALT, the program is malformed");
      end
   endtask

   task automatic resetDut();
      reset        = 1'b1;
      storePending = 1'b0;
      fillDmem     = 1'b1;
      repeat (resetCycles) @(negedge clk);
      fillDmem = 1'b0;
      reset    = 1'b0;
   endtask

   task automatic expectQuiet();
      verifyFlag("wbValid", wbValid, 1'b0);
      verifyFlag("dmemWrite", dmemWrite, 1'b0);
      verifyFlag("dmemRead", dmemRead, 1'b0);
      verifyFlag("halt", halt, 1'b0);
      verifyFlag("err", err, 1'b0);
   endtask

   // once per falling edge, outputs are settled here
   task automatic sampleOutputs(input logic errAllowed);
      if (wbValid)
         checkWriteback(wbReg, wbData);
      storePending = dmemWrite;
      if (dmemWrite) begin
         checkStore(dmemAddr, dmemWriteData);
         storeIdx   = dmemAddr[7:0];
         storeValue = dmemWriteData;
      end
      if (err && !errAllowed)
         failRun("err was raised although the program has only legal opcodes");
      if (errSeen && !err)
         failRun("err fell after it had been raised");
      if (haltSeen && !halt)
         failRun("halt fell before reset");
      errSeen  = errSeen || err;
      haltSeen = haltSeen || halt;
   endtask

   task automatic runProgram(input string name, input int len, input int illegalAt);
      logic sawIllegal;
      int   cycle;
      buildProgram(len, illegalAt);
      runModel(sawIllegal);
      errSeen    = 1'b0;
      haltSeen   = 1'b0;
      writesSeen = 0;
      storesSeen = 0;
      resetDut();
      cycle = 0;
      while (!halt) begin
         if (cycle < 3)
            expectQuiet();   // nothing can reach MEM this early
         sampleOutputs(sawIllegal);
         cycle++;
         @(negedge clk);
      end
      // every expected write and store is done once halt is up
      if (expReg.size() != 0 || expAddr.size() != 0)
         failRun($sformatf("%s run halted with %0d writes and %0d stores still expected",
                           name, expReg.size(), expAddr.size()));
      // pipe must stay quiet after halt
      repeat (4) begin
         sampleOutputs(sawIllegal);
         @(negedge clk);
      end
      verifyFlag("err", err, sawIllegal);
      $display("%s run: %0d writes and %0d stores matched", name, writesSeen, storesSeen);
   endtask

   initial begin
      runProgram("main", mainLen, -1);
      runProgram("illegal opcode", shortLen, 10 + pick(shortLen - 20));
      $display("TB PASSED");
      $finish;
   end

   initial begin
      #(watchdogNs);
      failRun($sformatf("timeout, HALT not reached within %0d ns", watchdogNs));
   end

endmodule

`default_nettype wire

// ==== proc.f ====
src/procPkg.sv
src/pipeBus.sv
src/regFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memWbStage.sv
src/proc.sv
dv/tb_proc.sv

// ==== src/decodeStage.sv ====
// ############################################################################
// Decode, RAW hazard stall (no forwarding, writeback bypasses in regFile),
// branch-pending and halted tracking, and the ID/EX register.
// Illegal opcodes set the sticky err and continue as NOP.
// ############################################################################
`timescale 1ns/10ps
`default_nettype none

module decodeStage import procPkg::*; (
   input  logic      clk,
   input  logic      reset,
   ifIdBus.consumer  ifId,
   idExBus.producer  idEx,
   exMemBus.consumer exMem,
   wbBus.consumer    wb,
   output logic      branchPending,
   output logic      halted,
   output logic      err
);

   instT   inst;
   ctrlT   ctrl;
   regSelT selA, selB, dest;
   logic   useA, useB;
   logic   illegal, isXfer;
   logic   hitA, hitB, stall, accept;
   dataT   imm, readDataA, readDataB;
   logic   pendFlag, haltFlag, errFlag;

   assign inst = ifId.inst;

   always_comb begin
      ctrl    = '0;
      illegal = 1'b0;
      useA    = 1'b0;
      useB    = 1'b0;
      selA    = inst.iFmt.rs;
      selB    = inst.iFmt.rd;    // store data for ST
      dest    = inst.iFmt.rd;
      imm     = {{11{inst.iFmt.imm[4]}}, inst.iFmt.imm};
      case (inst.rFmt.opcode)
         opAlu: begin
            selA          = inst.rFmt.rs;
            selB          = inst.rFmt.rt;
            dest          = inst.rFmt.rd;
            useA          = 1'b1;
            useB          = 1'b1;
            ctrl.aluOp    = aluOpT'(inst.rFmt.func);
            ctrl.regWrite = 1'b1;
         end
         opAddi, opXori, opAndni: begin
            useA          = 1'b1;
            ctrl.useImm   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = (inst.iFmt.opcode == opAddi) ? aluAdd :
                            (inst.iFmt.opcode == opXori) ? aluXor : aluAndn;
         end
         opLd: begin
            useA          = 1'b1;
            ctrl.useImm   = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         opSt: begin
            useA          = 1'b1;
            useB          = 1'b1;
            ctrl.useImm   = 1'b1;
            ctrl.memWrite = 1'b1;
         end
         opBeqz: begin
            useA            = 1'b1;
            ctrl.branchZero = 1'b1;
         end
         opBnez: begin
            useA               = 1'b1;
            ctrl.branchNonZero = 1'b1;
         end
         opJ: begin
            ctrl.jump = 1'b1;
            imm       = {{5{inst.jFmt.disp[10]}}, inst.jFmt.disp};
         end
         opNop:   ;
         opHalt:  ctrl.halt = 1'b1;
         default: illegal = 1'b1;   // travels on as NOP
      endcase
   end

   // producers still in EX or MEM; MEM/WB is bypassed
   assign hitA = useA && ((idEx.valid && idEx.ctrl.regWrite && idEx.dest == selA) ||
                          (exMem.valid && exMem.ctrl.regWrite && exMem.dest == selA));
   assign hitB = useB && ((idEx.valid && idEx.ctrl.regWrite && idEx.dest == selB) ||
                          (exMem.valid && exMem.ctrl.regWrite && exMem.dest == selB));

   assign stall      = ifId.valid && (hitA || hitB);
   assign ifId.ready = !stall && !haltFlag;
   assign accept     = ifId.valid && ifId.ready;
   assign isXfer     = ctrl.branchZero || ctrl.branchNonZero || ctrl.jump;

   // also block fetch while the branch or HALT still sits in IF/ID
   assign branchPending = pendFlag || (ifId.valid && isXfer);
   assign halted        = haltFlag || (ifId.valid && ctrl.halt);
   assign err           = errFlag;

   regFile rf (
      .clk       (clk),
      .reset     (reset),
      .readSelA  (selA),
      .readSelB  (selB),
      .readDataA (readDataA),
      .readDataB (readDataB),
      .wb        (wb)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         pendFlag   <= 1'b0;
         haltFlag   <= 1'b0;
         errFlag    <= 1'b0;
         idEx.valid <= 1'b0;
      end else begin
         idEx.valid <= accept;   // bubble on stall
         if (accept && isXfer)
            pendFlag <= 1'b1;
         else if (exMem.resolved)
            pendFlag <= 1'b0;
         if (accept && ctrl.halt)
            haltFlag <= 1'b1;
         if (accept && illegal)
            errFlag <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      idEx.ctrl      <= ctrl;
      idEx.pcNext    <= ifId.pcNext;
      idEx.srcA      <= readDataA;
      idEx.srcB      <= readDataB;
      idEx.imm       <= imm;
      idEx.storeData <= readDataB;
      idEx.dest      <= dest;
   end

   // nothing reaches IF/ID once HALT has been taken
   noFetchAfterHalt: assert property (@(posedge clk) disable iff (reset)
      haltFlag |-> !ifId.valid);

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
// ############################################################################
// ALU, branch resolution and the EX/MEM register. Branch feedback is
// combinational from ID/EX. LD/ST address is srcA plus the immediate.
// ############################################################################
`timescale 1ns/10ps
`default_nettype none

module executeStage import procPkg::*; (
   input  logic      clk,
   input  logic      reset,
   idExBus.consumer  idEx,
   exMemBus.producer exMem
);

   dataT opB;
   dataT aluOut;
   logic isZero, isBranch, taken;

   assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.srcB;

   always_comb begin
      case (idEx.ctrl.aluOp)
         aluAdd:  aluOut = idEx.srcA + opB;
         aluSub:  aluOut = idEx.srcA - opB;
         aluXor:  aluOut = idEx.srcA ^ opB;
         default: aluOut = idEx.srcA & ~opB;    // andn
      endcase
   end

   assign isZero   = (idEx.srcA == '0);
   assign isBranch = idEx.ctrl.branchZero || idEx.ctrl.branchNonZero || idEx.ctrl.jump;
   assign taken    = (idEx.ctrl.branchZero && isZero) ||
                     (idEx.ctrl.branchNonZero && !isZero) ||
                     idEx.ctrl.jump;

   assign exMem.resolved = idEx.valid && isBranch;
   assign exMem.redirect = exMem.resolved && taken;
   assign exMem.target   = idEx.pcNext + idEx.imm;

   always_ff @(posedge clk) begin
      if (reset)
         exMem.valid <= 1'b0;
      else
         exMem.valid <= idEx.valid;
   end

   always_ff @(posedge clk) begin
      exMem.ctrl      <= idEx.ctrl;
      exMem.result    <= aluOut;
      exMem.storeData <= idEx.storeData;
      exMem.dest      <= idEx.dest;
   end

endmodule

`default_nettype wire

// ==== src/fetchStage.sv ====
// ############################################################################
// PC and instruction fetch. instAddr is the PC itself, the memory read is
// combinational. Fetch stalls while a branch is pending or after HALT.
// ############################################################################
`timescale 1ns/10ps
`default_nettype none

module fetchStage import procPkg::*; (
   input  logic      clk,
   input  logic      reset,
   output dataT      instAddr,
   input  instT      instData,
   ifIdBus.producer  ifId,
   exMemBus.consumer exMem,
   input  logic      branchPending,
   input  logic      halted
);

   dataT pc;
   dataT pcPlus2;
   logic fetchEn;

   assign instAddr = pc;
   assign pcPlus2  = pc + 16'd2;
   // IF/ID free or draining this cycle
   assign fetchEn  = (!ifId.valid || ifId.ready) && !branchPending && !halted;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc         <= '0;
         ifId.valid <= 1'b0;
      end else if (fetchEn) begin
         pc         <= pcPlus2;
         ifId.valid <= 1'b1;
      end else begin
         if (ifId.ready)
            ifId.valid <= 1'b0;
         // pc already holds the fall-through address
         if (exMem.resolved && exMem.redirect)
            pc <= exMem.target;
      end
   end

   always_ff @(posedge clk) begin
      if (fetchEn) begin
         ifId.inst   <= instData;
         ifId.pcNext <= pcPlus2;
      end
   end

   // a resolving branch finds IF/ID empty
   emptyOnResolve: assert property (@(posedge clk) disable iff (reset)
      exMem.resolved |-> !ifId.valid);

endmodule

`default_nettype wire

// ==== src/memWbStage.sv ====
// ############################################################################
// Data memory access, MEM/WB register and writeback select. The external
// memory reads combinationally and writes on the rising edge.
// halt is sticky until reset.
// ############################################################################
`timescale 1ns/10ps
`default_nettype none

module memWbStage import procPkg::*; (
   input  logic      clk,
   input  logic      reset,
   exMemBus.consumer exMem,
   output dataT      dmemAddr,
   output dataT      dmemWriteData,
   output logic      dmemWrite,
   output logic      dmemRead,
   input  dataT      dmemReadData,
   wbBus.producer    wb,
   output logic      wbValid,
   output regSelT    wbReg,
   output dataT      wbData,
   output logic      halt
);

   logic haltInWb;   // HALT sitting in MEM/WB

   assign dmemAddr      = exMem.result;
   assign dmemWriteData = exMem.storeData;
   assign dmemWrite     = exMem.valid && exMem.ctrl.memWrite;
   assign dmemRead      = exMem.valid && exMem.ctrl.memRead;

   always_ff @(posedge clk) begin
      if (reset) begin
         wb.writeEnable <= 1'b0;
         haltInWb       <= 1'b0;
         halt           <= 1'b0;
      end else begin
         wb.writeEnable <= exMem.valid && exMem.ctrl.regWrite;
         haltInWb       <= exMem.valid && exMem.ctrl.halt;
         if (haltInWb)
            halt <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      wb.dest <= exMem.dest;
      wb.data <= exMem.ctrl.memRead ? dmemReadData : exMem.result;
   end

   assign wbValid = wb.writeEnable;
   assign wbReg   = wb.dest;
   assign wbData  = wb.data;

   oneMemOp: assert property (@(posedge clk) disable iff (reset)
      !(dmemWrite && dmemRead));

endmodule

`default_nettype wire

// ==== src/pipeBus.sv ====
// ############################################################################
// Stage-to-stage buses of the core. Only ifIdBus has back-pressure;
// later buses carry valid alone. exMemBus also returns branch feedback.
// ############################################################################
`timescale 1ns/10ps
`default_nettype none

interface ifIdBus import procPkg::*; ();
   logic valid;
   instT inst;
   dataT pcNext;
   logic ready;

   modport producer (output valid, inst, pcNext, input ready);
   modport consumer (input valid, inst, pcNext, output ready);
endinterface

interface idExBus import procPkg::*; ();
   logic   valid;
   ctrlT   ctrl;
   dataT   pcNext;
   dataT   srcA;
   dataT   srcB;
   dataT   imm;
   dataT   storeData;
   regSelT dest;

   modport producer (output valid, ctrl, pcNext, srcA, srcB, imm, storeData, dest);
   modport consumer (input valid, ctrl, pcNext, srcA, srcB, imm, storeData, dest);
endinterface

interface exMemBus import procPkg::*; ();
   logic   valid;
   ctrlT   ctrl;
   dataT   result;
   dataT   storeData;
   regSelT dest;
   logic   redirect;    // branch feedback, same cycle as resolve
   dataT   target;
   logic   resolved;

   modport producer (output valid, ctrl, result, storeData, dest, redirect, target, resolved);
   modport consumer (input valid, ctrl, result, storeData, dest, redirect, target, resolved);
endinterface

interface wbBus import procPkg::*; ();
   logic   writeEnable;
   regSelT dest;
   dataT   data;

   modport producer (output writeEnable, dest, data);
   modport consumer (input writeEnable, dest, data);
endinterface

`default_nettype wire

// ==== src/proc.sv ====
// ############################################################################
// Top of the 16-bit pipelined core. Instruction and data memories are
// external; both read combinationally in the same cycle.
// wbValid/wbReg/wbData trace every retiring register write.
// ############################################################################
`timescale 1ns/10ps
`default_nettype none

module proc import procPkg::*; (
   input  logic   clk,
   input  logic   reset,
   output dataT   instAddr,
   input  dataT   instData,
   output dataT   dmemAddr,
   output dataT   dmemWriteData,
   output logic   dmemWrite,
   output logic   dmemRead,
   input  dataT   dmemReadData,
   output logic   wbValid,
   output regSelT wbReg,
   output dataT   wbData,
   output logic   halt,
   output logic   err
);

   logic branchPending;
   logic halted;

   ifIdBus  ifIdIf ();
   idExBus  idExIf ();
   exMemBus exMemIf ();
   wbBus    wbIf ();

   fetchStage fetch (
      .clk           (clk),
      .reset         (reset),
      .instAddr      (instAddr),
      .instData      (instData),
      .ifId          (ifIdIf.producer),
      .exMem         (exMemIf.consumer),
      .branchPending (branchPending),
      .halted        (halted)
   );

   decodeStage decode (
      .clk           (clk),
      .reset         (reset),
      .ifId          (ifIdIf.consumer),
      .idEx          (idExIf.producer),
      .exMem         (exMemIf.consumer),
      .wb            (wbIf.consumer),
      .branchPending (branchPending),
      .halted        (halted),
      .err           (err)
   );

   executeStage execute (
      .clk   (clk),
      .reset (reset),
      .idEx  (idExIf.consumer),
      .exMem (exMemIf.producer)
   );

   memWbStage memWb (
      .clk           (clk),
      .reset         (reset),
      .exMem         (exMemIf.consumer),
      .dmemAddr      (dmemAddr),
      .dmemWriteData (dmemWriteData),
      .dmemWrite     (dmemWrite),
      .dmemRead      (dmemRead),
      .dmemReadData  (dmemReadData),
      .wb            (wbIf.producer),
      .wbValid       (wbValid),
      .wbReg         (wbReg),
      .wbData        (wbData),
      .halt          (halt)
   );

endmodule

`default_nettype wire

// ==== src/procPkg.sv ====
// ############################################################################
// Shared types of the 16-bit pipelined core: opcodes, ALU operations,
// the instruction word views and the decoded control bundle.
// All immediates are sign-extended, XORI and ANDNI included.
// Branch and jump displacements are in bytes, relative to PC + 2.
// ############################################################################
`default_nettype none

package procPkg;

   typedef logic [15:0] dataT;
   typedef logic [2:0]  regSelT;

   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opAddi  = 5'b01000,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opAlu   = 5'b11011    // register ops, selected by func
   } opcodeT;

   // encoding matches the func field of register ops
   typedef enum logic [1:0] {
      aluAdd  = 2'b00,
      aluSub  = 2'b01,
      aluXor  = 2'b10,
      aluAndn = 2'b11
   } aluOpT;

   typedef struct packed {
      opcodeT     opcode;
      regSelT     rs;
      regSelT     rt;
      regSelT     rd;
      logic [1:0] func;
   } rFmtT;

   typedef struct packed {
      opcodeT     opcode;
      regSelT     rd;       // dest, or store data for ST
      regSelT     rs;
      logic [4:0] imm;
   } iFmtT;

   typedef struct packed {
      opcodeT      opcode;
      logic [10:0] disp;
   } jFmtT;

   typedef union packed {
      rFmtT rFmt;
      iFmtT iFmt;
      jFmtT jFmt;
   } instT;

   typedef struct packed {
      aluOpT aluOp;
      logic  useImm;
      logic  memRead;
      logic  memWrite;
      logic  regWrite;
      logic  branchZero;
      logic  branchNonZero;
      logic  jump;
      logic  halt;
   } ctrlT;

endpackage

`default_nettype wire

// ==== src/regFile.sv ====
// ############################################################################
// Eight 16-bit registers, two combinational read ports, one write port.
// A write in the same cycle is bypassed to the readers. r0 is ordinary.
// ############################################################################
`timescale 1ns/10ps
`default_nettype none

module regFile import procPkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  regSelT readSelA,
   input  regSelT readSelB,
   output dataT   readDataA,
   output dataT   readDataB,
   wbBus.consumer wb
);

   dataT regs [8];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
      end else if (wb.writeEnable) begin
         regs[wb.dest] <= wb.data;
      end
   end

   assign readDataA = (wb.writeEnable && wb.dest == readSelA) ? wb.data : regs[readSelA];
   assign readDataB = (wb.writeEnable && wb.dest == readSelB) ? wb.data : regs[readSelB];

   // writeback is flushed by the second reset cycle
   noWriteInReset: assert property (@(posedge clk)
      reset && $past(reset) |-> !wb.writeEnable);

endmodule

`default_nettype wire
